/* files.f */
hdl/i3c_ccc_pkg.sv
hdl/i3c_csr_pkg.sv
hdl/ccc_addr_decode.sv
hdl/addr_csr_regs.sv
hdl/csr_read_resp.sv
hdl/i3c_addr_csr.sv
testbench/tb_clock_gen.sv
testbench/tb_i3c_addr_csr.sv

/* Bender.yml */
package:
  name: i3c_addr_csr

sources:
  - files:
      - hdl/i3c_ccc_pkg.sv
      - hdl/i3c_csr_pkg.sv
      - hdl/ccc_addr_decode.sv
      - hdl/addr_csr_regs.sv
      - hdl/csr_read_resp.sv
      - hdl/i3c_addr_csr.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_i3c_addr_csr.sv

/* testbench/tb_i3c_addr_csr.sv */
`timescale 1ns/1ns

module tb_i3c_addr_csr
    import i3c_ccc_pkg::*;
    import i3c_csr_pkg::*;
();

    localparam int unsigned AddrWidth     = 12;
    localparam int unsigned TimeoutCycles = 2000;  // Tests take about 250 cycles
    localparam int unsigned AckLimit      = 4;
    localparam logic [31:0] StaticMask    = 32'h0000_807f;  // Static address and valid

    logic                    clk;
    logic                    reset;
    logic                    cpuif_req;
    logic                    cpuif_req_is_wr;
    logic [AddrWidth-1:0]    cpuif_addr;
    logic [CsrDataWidth-1:0] cpuif_wr_data;
    logic [CsrDataWidth-1:0] cpuif_wr_biten;
    logic                    cpuif_rd_ack;
    logic                    cpuif_rd_err;
    logic                    cpuif_wr_ack;
    logic                    cpuif_wr_err;
    logic [CsrDataWidth-1:0] cpuif_rd_data;
    logic                    set_dasa;
    logic                    set_dasa_valid;
    logic                    set_dasa_virt;
    logic                    rstdaa;
    logic [I3cAddrWidth-1:0] set_dasa_addr;
    logic [I3cAddrWidth-1:0] newda;
    logic [I3cAddrWidth-1:0] dyn_addr;
    logic [I3cAddrWidth-1:0] virt_dyn_addr;
    logic                    set_newda;
    logic                    set_newda_virt;
    logic                    set_aasa;
    logic                    set_aasa_virt;
    logic                    rst_action_valid;
    logic                    dyn_addr_valid;
    logic                    virt_dyn_addr_valid;
    logic [7:0]              rst_action;
    logic [7:0]              rst_action_out;

    // Reference model of the three registers
    logic [31:0] exp_dev;
    logic [31:0] exp_virt;
    logic [31:0] exp_rst;
    logic [31:0] nxt_dev;
    logic [31:0] nxt_virt;
    logic [31:0] nxt_rst;
    int unsigned cycle_count = 0;

    tb_clock_gen i_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    i3c_addr_csr #(
        .CsrAddrWidth(AddrWidth)
    ) i_i3c_addr_csr (
        .clk_i                 (clk),
        .reset_i               (reset),
        .cpuif_req_i           (cpuif_req),
        .cpuif_req_is_wr_i     (cpuif_req_is_wr),
        .cpuif_addr_i          (cpuif_addr),
        .cpuif_wr_data_i       (cpuif_wr_data),
        .cpuif_wr_biten_i      (cpuif_wr_biten),
        .cpuif_rd_ack_o        (cpuif_rd_ack),
        .cpuif_rd_err_o        (cpuif_rd_err),
        .cpuif_rd_data_o       (cpuif_rd_data),
        .cpuif_wr_ack_o        (cpuif_wr_ack),
        .cpuif_wr_err_o        (cpuif_wr_err),
        .set_dasa_i            (set_dasa),
        .set_dasa_addr_i       (set_dasa_addr),
        .set_dasa_valid_i      (set_dasa_valid),
        .set_dasa_virt_i       (set_dasa_virt),
        .rstdaa_i              (rstdaa),
        .set_newda_i           (set_newda),
        .newda_i               (newda),
        .set_newda_virt_i      (set_newda_virt),
        .set_aasa_i            (set_aasa),
        .set_aasa_virt_i       (set_aasa_virt),
        .rst_action_valid_i    (rst_action_valid),
        .rst_action_i          (rst_action),
        .dyn_addr_o            (dyn_addr),
        .dyn_addr_valid_o      (dyn_addr_valid),
        .virt_dyn_addr_o       (virt_dyn_addr),
        .virt_dyn_addr_valid_o (virt_dyn_addr_valid),
        .rst_action_o          (rst_action_out)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_count);
            $display("tests failed");
            $fatal(1);
        end
    end

    task automatic check_word(input string name, input logic [CsrDataWidth-1:0] act,
                              input logic [CsrDataWidth-1:0] exp);
        if (act !== exp) begin
            $display("Error: %s = 0x%08h, expected 0x%08h", name, act, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] with_dyn(input logic [31:0] w, input logic [6:0] a,
                                             input logic v);
        logic [31:0] r;
        r        = w;
        r[22:16] = a;
        r[31]    = v;
        return r;
    endfunction

    function automatic logic [31:0] sw_merge(input logic [31:0] w, input logic [31:0] data,
                                             input logic [31:0] biten);
        logic [31:0] m;
        m = biten & StaticMask;
        return (w & ~m) | (data & m);
    endfunction

    function automatic logic [AddrWidth-1:0] pick_unmapped_offset();
        logic [AddrWidth-1:0] off;
        off = AddrWidth'($urandom);
        while (off == 'h0 || off == 'h4 || off == 'h8) begin
            off = AddrWidth'($urandom);
        end
        return off;
    endfunction

    task automatic clear_strobes();
        set_dasa         <= 1'b0;
        set_dasa_valid   <= 1'b0;
        set_dasa_virt    <= 1'b0;
        rstdaa           <= 1'b0;
        set_newda        <= 1'b0;
        set_newda_virt   <= 1'b0;
        set_aasa         <= 1'b0;
        set_aasa_virt    <= 1'b0;
        rst_action_valid <= 1'b0;
    endtask

    task automatic hold_model();
        nxt_dev  = exp_dev;
        nxt_virt = exp_virt;
        nxt_rst  = exp_rst;
    endtask

    task automatic check_outputs();
        check_word("dyn_addr_o", CsrDataWidth'(dyn_addr), CsrDataWidth'(exp_dev[22:16]));
        check_flag("dyn_addr_valid_o", dyn_addr_valid, exp_dev[31]);
        check_word("virt_dyn_addr_o", CsrDataWidth'(virt_dyn_addr),
                   CsrDataWidth'(exp_virt[22:16]));
        check_flag("virt_dyn_addr_valid_o", virt_dyn_addr_valid, exp_virt[31]);
        check_word("rst_action_o", CsrDataWidth'(rst_action_out), CsrDataWidth'(exp_rst[7:0]));
    endtask

    // Strobes raised on the last edge take effect two edges later
    task automatic ccc_settle();
        @(posedge clk);
        clear_strobes();
        @(negedge clk);
        check_outputs();
        exp_dev  = nxt_dev;
        exp_virt = nxt_virt;
        exp_rst  = nxt_rst;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic sw_request(input logic is_wr, input logic [AddrWidth-1:0] addr,
                              input logic [31:0] data, input logic [31:0] biten);
        int unsigned waited;
        @(posedge clk);
        cpuif_req       <= 1'b1;
        cpuif_req_is_wr <= is_wr;
        cpuif_addr      <= addr;
        cpuif_wr_data   <= data;
        cpuif_wr_biten  <= biten;
        @(posedge clk);
        cpuif_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpuif_rd_ack && !cpuif_wr_ack && waited < AckLimit);
        if (waited != 1) begin
            $display("Software request at offset 0x%0h was not acked on the next cycle", addr);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic ack_released();
        @(negedge clk);
        check_flag("cpuif_rd_ack_o", cpuif_rd_ack, 1'b0);
        check_flag("cpuif_wr_ack_o", cpuif_wr_ack, 1'b0);
    endtask

    task automatic sw_read(input logic [AddrWidth-1:0] addr, input logic exp_err,
                           input logic [31:0] exp_data);
        sw_request(1'b0, addr, '0, '0);
        check_flag("cpuif_rd_ack_o", cpuif_rd_ack, 1'b1);
        check_flag("cpuif_wr_ack_o", cpuif_wr_ack, 1'b0);
        check_flag("cpuif_rd_err_o", cpuif_rd_err, exp_err);
        check_word("cpuif_rd_data_o", cpuif_rd_data, exp_data);
        ack_released();
    endtask

    task automatic sw_write(input logic [AddrWidth-1:0] addr, input logic [31:0] data,
                            input logic [31:0] biten, input logic exp_err);
        sw_request(1'b1, addr, data, biten);
        check_flag("cpuif_wr_ack_o", cpuif_wr_ack, 1'b1);
        check_flag("cpuif_rd_ack_o", cpuif_rd_ack, 1'b0);
        check_flag("cpuif_wr_err_o", cpuif_wr_err, exp_err);
        ack_released();
    endtask

    task automatic read_all();
        sw_read('h0, 1'b0, exp_dev);
        sw_read('h4, 1'b0, exp_virt);
        sw_read('h8, 1'b0, exp_rst);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_outputs();
        read_all();
    endtask

    task automatic test_sw_static_write();
        logic [31:0] data;
        logic [31:0] biten;
        data  = $urandom;
        biten = $urandom;
        sw_write('h0, data, biten, 1'b0);
        exp_dev = sw_merge(exp_dev, data, biten);
        data    = $urandom;
        biten   = $urandom;
        sw_write('h4, data, biten, 1'b0);
        exp_virt = sw_merge(exp_virt, data, biten);
        read_all();
    endtask

    task automatic test_setdasa_rstdaa();
        logic [6:0] a_phys;
        logic [6:0] a_virt;
        a_phys = 7'($urandom);
        a_virt = 7'($urandom);
        @(posedge clk);
        set_dasa       <= 1'b1;
        set_dasa_valid <= 1'b1;
        set_dasa_addr  <= a_phys;
        hold_model();
        nxt_dev = with_dyn(exp_dev, a_phys, 1'b1);
        ccc_settle();
        @(posedge clk);
        set_dasa       <= 1'b1;
        set_dasa_valid <= 1'b1;
        set_dasa_virt  <= 1'b1;
        set_dasa_addr  <= a_virt;
        hold_model();
        nxt_virt = with_dyn(exp_virt, a_virt, 1'b1);
        ccc_settle();
        read_all();
        // RSTDAA aimed at the main device only
        @(posedge clk);
        rstdaa <= 1'b1;
        hold_model();
        nxt_dev = with_dyn(exp_dev, 7'h0, 1'b0);
        ccc_settle();
        read_all();
    endtask

    task automatic test_setnewda_priority();
        logic [6:0] a;
        a = 7'($urandom);
        @(posedge clk);
        set_newda <= 1'b1;
        newda     <= a;
        hold_model();
        nxt_dev = with_dyn(exp_dev, a, 1'b1);
        ccc_settle();
        // RSTDAA on the virtual target against SETNEWDA on the main one
        @(posedge clk);
        rstdaa        <= 1'b1;
        set_dasa_virt <= 1'b1;
        set_newda     <= 1'b1;
        newda         <= a ^ 7'h55;
        hold_model();
        nxt_virt = with_dyn(exp_virt, 7'h0, 1'b0);
        ccc_settle();
        // SETDASA on the main device against SETNEWDA on the virtual one
        @(posedge clk);
        set_dasa       <= 1'b1;
        set_dasa_valid <= 1'b1;
        set_dasa_addr  <= a ^ 7'h2a;
        set_newda      <= 1'b1;
        set_newda_virt <= 1'b1;
        newda          <= 7'($urandom);
        hold_model();
        nxt_dev = with_dyn(exp_dev, a ^ 7'h2a, 1'b1);
        ccc_settle();
        read_all();
    endtask

    task automatic test_setaasa();
        logic [31:0] data;
        data = $urandom;
        sw_write('h0, data, 32'hffff_ffff, 1'b0);
        exp_dev = sw_merge(exp_dev, data, 32'hffff_ffff);
        data    = $urandom;
        sw_write('h4, data, 32'hffff_ffff, 1'b0);
        exp_virt = sw_merge(exp_virt, data, 32'hffff_ffff);
        @(posedge clk);
        set_aasa      <= 1'b1;
        set_aasa_virt <= 1'b1;
        hold_model();
        nxt_dev  = with_dyn(exp_dev, exp_dev[6:0], 1'b1);
        nxt_virt = with_dyn(exp_virt, exp_virt[6:0], 1'b1);
        ccc_settle();
        read_all();
    endtask

    task automatic test_errors_rstact();
        logic [7:0]           act;
        logic [AddrWidth-1:0] off;
        act = 8'($urandom);
        if (act == 8'h00) begin
            act = 8'h01;  // Must differ from the reset value
        end
        @(posedge clk);
        rst_action_valid <= 1'b1;
        rst_action       <= act;
        hold_model();
        nxt_rst = {24'h0, act};
        ccc_settle();
        off = pick_unmapped_offset();
        sw_read(off, 1'b1, 32'h0);
        sw_write(off, $urandom, 32'hffff_ffff, 1'b1);
        sw_write('h8, $urandom, 32'hffff_ffff, 1'b1);  // RSTACT_PARAMS is read-only
        read_all();
    endtask

    initial begin
        void'($urandom(32'h48b63985));
        cpuif_req        = 1'b0;
        cpuif_req_is_wr  = 1'b0;
        cpuif_addr       = '0;
        cpuif_wr_data    = '0;
        cpuif_wr_biten   = '0;
        set_dasa_addr    = '0;
        newda            = '0;
        rst_action       = '0;
        set_dasa         = 1'b0;
        set_dasa_valid   = 1'b0;
        set_dasa_virt    = 1'b0;
        rstdaa           = 1'b0;
        set_newda        = 1'b0;
        set_newda_virt   = 1'b0;
        set_aasa         = 1'b0;
        set_aasa_virt    = 1'b0;
        rst_action_valid = 1'b0;
        exp_dev  = '0;
        exp_virt = '0;
        exp_rst  = '0;
        hold_model();
        @(negedge reset);
        test_reset_state();
        test_sw_static_write();
        test_setdasa_rstdaa();
        test_setnewda_priority();
        test_setaasa();
        test_errors_rstact();
        $display("all tests passed");
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int unsigned ResetCycles = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 10 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (ResetCycles) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

/* hdl/i3c_addr_csr.sv */
`timescale 1ns/1ns

module i3c_addr_csr
    import i3c_ccc_pkg::*;
    import i3c_csr_pkg::*;
#(
    parameter int unsigned CsrAddrWidth = 12
) (
    input  logic                    clk_i,
    input  logic                    reset_i,

    // Software CSR port
    input  logic                    cpuif_req_i,
    input  logic                    cpuif_req_is_wr_i,
    input  logic [CsrAddrWidth-1:0] cpuif_addr_i,
    input  logic [CsrDataWidth-1:0] cpuif_wr_data_i,
    input  logic [CsrDataWidth-1:0] cpuif_wr_biten_i,
    output logic                    cpuif_rd_ack_o,
    output logic                    cpuif_rd_err_o,
    output logic [CsrDataWidth-1:0] cpuif_rd_data_o,
    output logic                    cpuif_wr_ack_o,
    output logic                    cpuif_wr_err_o,

    // CCC strobes from the bus side
    input  logic                    set_dasa_i,
    input  logic [I3cAddrWidth-1:0] set_dasa_addr_i,
    input  logic                    set_dasa_valid_i,
    input  logic                    set_dasa_virt_i,
    input  logic                    rstdaa_i,
    input  logic                    set_newda_i,
    input  logic [I3cAddrWidth-1:0] newda_i,
    input  logic                    set_newda_virt_i,
    input  logic                    set_aasa_i,
    input  logic                    set_aasa_virt_i,
    input  logic                    rst_action_valid_i,
    input  logic [7:0]              rst_action_i,

    output logic [I3cAddrWidth-1:0] dyn_addr_o,
    output logic                    dyn_addr_valid_o,
    output logic [I3cAddrWidth-1:0] virt_dyn_addr_o,
    output logic                    virt_dyn_addr_valid_o,
    output logic [7:0]              rst_action_o
);

    ccc_op_e                 ccc_op;
    logic [1:0]              tgt_mask;
    logic [I3cAddrWidth-1:0] op_addr;
    logic                    rstact_valid;
    logic [7:0]              rstact_value;
    csr_reg_e                reg_sel;
    logic                    sw_wr_en;
    logic                    sw_rd_en;
    logic                    sw_err_wr;
    logic                    sw_err_rd;
    logic [CsrDataWidth-1:0] device_addr_q;
    logic [CsrDataWidth-1:0] virt_device_addr_q;
    logic [CsrDataWidth-1:0] rstact_q;

    ccc_addr_decode #(
        .CsrAddrWidth(CsrAddrWidth)
    ) i_decode (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .set_dasa_i         (set_dasa_i),
        .set_dasa_addr_i    (set_dasa_addr_i),
        .set_dasa_valid_i   (set_dasa_valid_i),
        .set_dasa_virt_i    (set_dasa_virt_i),
        .rstdaa_i           (rstdaa_i),
        .set_newda_i        (set_newda_i),
        .newda_i            (newda_i),
        .set_newda_virt_i   (set_newda_virt_i),
        .set_aasa_i         (set_aasa_i),
        .set_aasa_virt_i    (set_aasa_virt_i),
        .rst_action_valid_i (rst_action_valid_i),
        .rst_action_i       (rst_action_i),
        .cpuif_req_i        (cpuif_req_i),
        .cpuif_req_is_wr_i  (cpuif_req_is_wr_i),
        .cpuif_addr_i       (cpuif_addr_i),
        .ccc_op_o           (ccc_op),
        .tgt_mask_o         (tgt_mask),
        .op_addr_o          (op_addr),
        .rstact_valid_o     (rstact_valid),
        .rstact_value_o     (rstact_value),
        .reg_sel_o          (reg_sel),
        .sw_wr_en_o         (sw_wr_en),
        .sw_rd_en_o         (sw_rd_en),
        .sw_err_wr_o        (sw_err_wr),
        .sw_err_rd_o        (sw_err_rd)
    );

    addr_csr_regs i_regs (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .ccc_op_i              (ccc_op),
        .tgt_mask_i            (tgt_mask),
        .op_addr_i             (op_addr),
        .rstact_valid_i        (rstact_valid),
        .rstact_value_i        (rstact_value),
        .reg_sel_i             (reg_sel),
        .sw_wr_en_i            (sw_wr_en),
        .wr_data_i             (cpuif_wr_data_i),
        .wr_biten_i            (cpuif_wr_biten_i),
        .device_addr_q_o       (device_addr_q),
        .virt_device_addr_q_o  (virt_device_addr_q),
        .rstact_q_o            (rstact_q),
        .dyn_addr_o            (dyn_addr_o),
        .dyn_addr_valid_o      (dyn_addr_valid_o),
        .virt_dyn_addr_o       (virt_dyn_addr_o),
        .virt_dyn_addr_valid_o (virt_dyn_addr_valid_o),
        .rst_action_o          (rst_action_o)
    );

    csr_read_resp i_resp (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .reg_sel_i            (reg_sel),
        .sw_rd_en_i           (sw_rd_en),
        .sw_wr_en_i           (sw_wr_en),
        .sw_err_rd_i          (sw_err_rd),
        .sw_err_wr_i          (sw_err_wr),
        .device_addr_q_i      (device_addr_q),
        .virt_device_addr_q_i (virt_device_addr_q),
        .rstact_q_i           (rstact_q),
        .rd_ack_o             (cpuif_rd_ack_o),
        .rd_err_o             (cpuif_rd_err_o),
        .rd_data_o            (cpuif_rd_data_o),
        .wr_ack_o             (cpuif_wr_ack_o),
        .wr_err_o             (cpuif_wr_err_o)
    );

endmodule

/* hdl/csr_read_resp.sv */
`timescale 1ns/1ns

module csr_read_resp
    import i3c_csr_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  csr_reg_e                reg_sel_i,
    input  logic                    sw_rd_en_i,
    input  logic                    sw_wr_en_i,
    input  logic                    sw_err_rd_i,
    input  logic                    sw_err_wr_i,

    input  logic [CsrDataWidth-1:0] device_addr_q_i,
    input  logic [CsrDataWidth-1:0] virt_device_addr_q_i,
    input  logic [CsrDataWidth-1:0] rstact_q_i,

    output logic                    rd_ack_o,
    output logic                    rd_err_o,
    output logic [CsrDataWidth-1:0] rd_data_o,
    output logic                    wr_ack_o,
    output logic                    wr_err_o
);

    logic [CsrDataWidth-1:0] rd_data_d;

    // Zero unless a mapped read is accepted
    always_comb begin
        rd_data_d = '0;
        if (sw_rd_en_i) begin
            case (reg_sel_i)
                REG_DEVICE_ADDR:      rd_data_d = device_addr_q_i;
                REG_VIRT_DEVICE_ADDR: rd_data_d = virt_device_addr_q_i;
                REG_RSTACT:           rd_data_d = rstact_q_i;
                default:              rd_data_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ack_o <= 1'b0;
            rd_err_o <= 1'b0;
            wr_ack_o <= 1'b0;
            wr_err_o <= 1'b0;
        end else begin
            rd_ack_o <= sw_rd_en_i || sw_err_rd_i;  // Rejected reads are acked too
            rd_err_o <= sw_err_rd_i;
            wr_ack_o <= sw_wr_en_i || sw_err_wr_i;
            wr_err_o <= sw_err_wr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_data_o <= rd_data_d;
    end

    a_one_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        !(rd_ack_o && wr_ack_o));

endmodule

/* hdl/addr_csr_regs.sv */
`timescale 1ns/1ns

module addr_csr_regs
    import i3c_ccc_pkg::*;
    import i3c_csr_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  ccc_op_e                 ccc_op_i,
    input  logic [1:0]              tgt_mask_i,
    input  logic [I3cAddrWidth-1:0] op_addr_i,
    input  logic                    rstact_valid_i,
    input  logic [7:0]              rstact_value_i,

    input  csr_reg_e                reg_sel_i,
    input  logic                    sw_wr_en_i,
    input  logic [CsrDataWidth-1:0] wr_data_i,
    input  logic [CsrDataWidth-1:0] wr_biten_i,

    output logic [CsrDataWidth-1:0] device_addr_q_o,
    output logic [CsrDataWidth-1:0] virt_device_addr_q_o,
    output logic [CsrDataWidth-1:0] rstact_q_o,

    output logic [I3cAddrWidth-1:0] dyn_addr_o,
    output logic                    dyn_addr_valid_o,
    output logic [I3cAddrWidth-1:0] virt_dyn_addr_o,
    output logic                    virt_dyn_addr_valid_o,
    output logic [7:0]              rst_action_o
);

    localparam logic [CsrDataWidth-1:0] AddrOnes = CsrDataWidth'((1 << I3cAddrWidth) - 1);
    localparam logic [CsrDataWidth-1:0] SwWrMask =
        (AddrOnes << StaticAddrLsb) | (CsrDataWidth'(1) << StaticValidBit);
    localparam logic [CsrDataWidth-1:0] DynMask =
        (AddrOnes << DynAddrLsb) | (CsrDataWidth'(1) << DynValidBit);
    localparam logic [CsrDataWidth-1:0] AddrRsvd = ~(SwWrMask | DynMask);
    localparam logic [CsrDataWidth-1:0] RstMask  = CsrDataWidth'(8'hff) << RstActionLsb;

    logic [CsrDataWidth-1:0] sw_be;
    logic [CsrDataWidth-1:0] rstact_q;

    // Software reaches the static fields only
    assign sw_be = wr_biten_i & SwWrMask;

    // One address register per target, indexed like tgt_mask
    for (genvar i = 0; i < 2; i++) begin : g_tgt
        localparam csr_reg_e SwSel = (i == TgtPhys) ? REG_DEVICE_ADDR : REG_VIRT_DEVICE_ADDR;

        logic [CsrDataWidth-1:0] addr_q;
        logic [CsrDataWidth-1:0] addr_d;
        logic                    sw_hit;

        assign sw_hit = sw_wr_en_i && (reg_sel_i == SwSel);

        always_comb begin
            addr_d = addr_q;
            if (sw_hit) begin
                addr_d = (addr_q & ~sw_be) | (wr_data_i & sw_be);
            end
            if (tgt_mask_i[i]) begin
                case (ccc_op_i)
                    CCC_SETDASA, CCC_SETNEWDA: begin
                        addr_d[DynAddrLsb +: I3cAddrWidth] = op_addr_i;
                        addr_d[DynValidBit]                = 1'b1;
                    end
                    CCC_RSTDAA: begin
                        addr_d[DynAddrLsb +: I3cAddrWidth] = '0;
                        addr_d[DynValidBit]                = 1'b0;
                    end
                    CCC_SETAASA: begin
                        // Static address as it was before any same-cycle write
                        addr_d[DynAddrLsb +: I3cAddrWidth] =
                            addr_q[StaticAddrLsb +: I3cAddrWidth];
                        addr_d[DynValidBit]                = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end

        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                addr_q <= '0;
            end else begin
                addr_q <= addr_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rstact_q <= '0;
        end else if (rstact_valid_i) begin
            rstact_q[RstActionLsb +: 8] <= rstact_value_i;
        end
    end

    assign device_addr_q_o      = g_tgt[TgtPhys].addr_q;
    assign virt_device_addr_q_o = g_tgt[TgtVirt].addr_q;
    assign rstact_q_o           = rstact_q;

    assign dyn_addr_o            = device_addr_q_o[DynAddrLsb +: I3cAddrWidth];
    assign dyn_addr_valid_o      = device_addr_q_o[DynValidBit];
    assign virt_dyn_addr_o       = virt_device_addr_q_o[DynAddrLsb +: I3cAddrWidth];
    assign virt_dyn_addr_valid_o = virt_device_addr_q_o[DynValidBit];
    assign rst_action_o          = rstact_q[RstActionLsb +: 8];

    a_rsvd_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        ((device_addr_q_o & AddrRsvd) == '0) &&
        ((virt_device_addr_q_o & AddrRsvd) == '0) &&
        ((rstact_q & ~RstMask) == '0));

endmodule

/* hdl/ccc_addr_decode.sv */
`timescale 1ns/1ns

module ccc_addr_decode
    import i3c_ccc_pkg::*;
    import i3c_csr_pkg::*;
#(
    parameter int unsigned CsrAddrWidth = 12
) (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    set_dasa_i,
    input  logic [I3cAddrWidth-1:0] set_dasa_addr_i,
    input  logic                    set_dasa_valid_i,
    input  logic                    set_dasa_virt_i,
    input  logic                    rstdaa_i,
    input  logic                    set_newda_i,
    input  logic [I3cAddrWidth-1:0] newda_i,
    input  logic                    set_newda_virt_i,
    input  logic                    set_aasa_i,
    input  logic                    set_aasa_virt_i,
    input  logic                    rst_action_valid_i,
    input  logic [7:0]              rst_action_i,

    input  logic                    cpuif_req_i,
    input  logic                    cpuif_req_is_wr_i,
    input  logic [CsrAddrWidth-1:0] cpuif_addr_i,

    output ccc_op_e                 ccc_op_o,
    output logic [1:0]              tgt_mask_o,
    output logic [I3cAddrWidth-1:0] op_addr_o,
    output logic                    rstact_valid_o,
    output logic [7:0]              rstact_value_o,
    output csr_reg_e                reg_sel_o,
    output logic                    sw_wr_en_o,
    output logic                    sw_rd_en_o,
    output logic                    sw_err_wr_o,
    output logic                    sw_err_rd_o
);

    ccc_op_e                 ccc_op_d;
    logic [1:0]              tgt_mask_d;
    logic [I3cAddrWidth-1:0] op_addr_d;
    logic                    sw_wr;
    logic                    sw_rd;
    logic                    sw_wr_ok;

    // RSTDAA and SETDASA share the SETDASA target flag
    always_comb begin
        ccc_op_d   = CCC_NONE;
        tgt_mask_d = '0;
        op_addr_d  = '0;
        if (rstdaa_i) begin
            ccc_op_d            = CCC_RSTDAA;
            tgt_mask_d[TgtPhys] = ~set_dasa_virt_i;
            tgt_mask_d[TgtVirt] = set_dasa_virt_i;
        end else if (set_dasa_i && set_dasa_valid_i) begin  // Address qualified by parser
            ccc_op_d            = CCC_SETDASA;
            tgt_mask_d[TgtPhys] = ~set_dasa_virt_i;
            tgt_mask_d[TgtVirt] = set_dasa_virt_i;
            op_addr_d           = set_dasa_addr_i;
        end else if (set_newda_i) begin
            ccc_op_d            = CCC_SETNEWDA;
            tgt_mask_d[TgtPhys] = ~set_newda_virt_i;
            tgt_mask_d[TgtVirt] = set_newda_virt_i;
            op_addr_d           = newda_i;
        end else if (set_aasa_i || set_aasa_virt_i) begin
            ccc_op_d            = CCC_SETAASA;  // Both targets possible
            tgt_mask_d[TgtPhys] = set_aasa_i;
            tgt_mask_d[TgtVirt] = set_aasa_virt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ccc_op_o       <= CCC_NONE;
            tgt_mask_o     <= '0;
            rstact_valid_o <= 1'b0;
        end else begin
            ccc_op_o       <= ccc_op_d;
            tgt_mask_o     <= tgt_mask_d;
            rstact_valid_o <= rst_action_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        op_addr_o      <= op_addr_d;
        rstact_value_o <= rst_action_i;
    end

    always_comb begin
        case (cpuif_addr_i)
            CsrAddrWidth'(AddrDeviceAddr):     reg_sel_o = REG_DEVICE_ADDR;
            CsrAddrWidth'(AddrVirtDeviceAddr): reg_sel_o = REG_VIRT_DEVICE_ADDR;
            CsrAddrWidth'(AddrRstactParams):   reg_sel_o = REG_RSTACT;
            default:                           reg_sel_o = REG_NONE;
        endcase
    end

    assign sw_wr    = cpuif_req_i && cpuif_req_is_wr_i;
    assign sw_rd    = cpuif_req_i && !cpuif_req_is_wr_i;
    assign sw_wr_ok = (reg_sel_o == REG_DEVICE_ADDR) || (reg_sel_o == REG_VIRT_DEVICE_ADDR);

    assign sw_wr_en_o  = sw_wr && sw_wr_ok;
    assign sw_err_wr_o = sw_wr && !sw_wr_ok;  // RSTACT is read-only
    assign sw_rd_en_o  = sw_rd && (reg_sel_o != REG_NONE);
    assign sw_err_rd_o = sw_rd && (reg_sel_o == REG_NONE);

    a_op_has_target: assert property (@(posedge clk_i) disable iff (reset_i)
        (ccc_op_o != CCC_NONE) |-> (tgt_mask_o != '0));

endmodule

/* hdl/i3c_csr_pkg.sv */
package i3c_csr_pkg;

    localparam int unsigned CsrDataWidth = 32;

    // Byte offsets of the standby controller registers
    localparam int unsigned AddrDeviceAddr     = 'h0;
    localparam int unsigned AddrVirtDeviceAddr = 'h4;
    localparam int unsigned AddrRstactParams   = 'h8;

    typedef enum logic [1:0] {
        REG_DEVICE_ADDR,
        REG_VIRT_DEVICE_ADDR,
        REG_RSTACT,
        REG_NONE  // Unmapped offset
    } csr_reg_e;

    // Layout shared by DEVICE_ADDR and VIRT_DEVICE_ADDR
    localparam int unsigned StaticAddrLsb  = 0;   // Bits 6..0
    localparam int unsigned StaticValidBit = 15;
    localparam int unsigned DynAddrLsb     = 16;  // Bits 22..16
    localparam int unsigned DynValidBit    = 31;

    // Action code of RSTACT_PARAMS in bits 7..0
    localparam int unsigned RstActionLsb = 0;

endpackage

/* hdl/i3c_ccc_pkg.sv */
package i3c_ccc_pkg;

    // Static and dynamic I3C addresses
    localparam int unsigned I3cAddrWidth = 7;

    // Address-changing CCCs after priority resolution
    typedef enum logic [2:0] {
        CCC_NONE,
        CCC_SETDASA,
        CCC_RSTDAA,
        CCC_SETNEWDA,
        CCC_SETAASA
    } ccc_op_e;

    // Bit indices into the two-bit target mask
    localparam int unsigned TgtPhys = 0;  // Main device
    localparam int unsigned TgtVirt = 1;  // Virtual target

endpackage
